/* tb.f */
verilog/spi_pkg.sv
verilog/spi_regs.sv
verilog/spi_master.sv
verilog/spi_slave.sv
verilog/spi_pads.sv
verilog/spi_top.sv
tb/spi_tb.sv

/* tb/spi_tb.sv */
/*
 * SPI subsystem testbench
 * Loops the master pins back onto the slave pins and runs a table
 * of transfers through the register port, then checks reset state,
 * readback, interrupt flags, the divider floor and dropped TX writes
 */
`timescale 1ns/1ns
`default_nettype none

module spi_tb;

   localparam int NFIXED     = 5;              // Hand-picked rows
   localparam int NRAND      = 8;              // Random rows
   localparam int NROWS      = NFIXED + NRAND;
   localparam int POLL_LIMIT = 2000;           // STATUS polls before giving up

   logic                sys_clk;
   logic                reset;
   logic                reg_write;
   logic                reg_read;
   spi_pkg::reg_addr_t  reg_addr;
   spi_pkg::reg_data_t  reg_wdata;
   spi_pkg::reg_data_t  reg_rdata;
   logic                reg_rvalid;
   logic                irq;
   wire spi_pkg::gpio_t gpio;

   string               row_name  [NROWS];     // Transfer table
   spi_pkg::clk_div_t   row_div   [NROWS];
   spi_pkg::spi_byte_t  row_mbyte [NROWS];
   spi_pkg::spi_byte_t  row_sbyte [NROWS];

   int                  checks;
   int                  errors;
   int                  timeouts;
   int unsigned         seed_val;
   spi_pkg::reg_data_t  rdata;

   spi_top spi_top_i (
      .sys_clk, .reset,
      .reg_write, .reg_read, .reg_addr, .reg_wdata,
      .reg_rdata, .reg_rvalid, .irq,
      .gpio
   );

   //########################################
   // Pin loopback
   //########################################
   assign gpio[spi_pkg::PIN_S_SCLK] = gpio[spi_pkg::PIN_M_SCLK];
   assign gpio[spi_pkg::PIN_S_MOSI] = gpio[spi_pkg::PIN_M_MOSI];
   assign gpio[spi_pkg::PIN_S_SS]   = gpio[spi_pkg::PIN_M_SS];
   assign gpio[spi_pkg::PIN_M_MISO] = gpio[spi_pkg::PIN_S_MISO];  // Slave reply to master

   for (genvar i = 0; i < spi_pkg::NGPIO; i++) begin : g_pull
      if (i < spi_pkg::PIN_M_SCLK || i > spi_pkg::PIN_S_SS) begin : g_unused
         pulldown pd (gpio[i]);                // Unused pins rest low
      end
   end

   initial begin
      sys_clk = 1'b0;
      forever #10 sys_clk = ~sys_clk;          // 20 ns period
   end

   //########################################
   // Checks
   //########################################
   task automatic check_data(input string name, input spi_pkg::reg_data_t expected,
                             input spi_pkg::reg_data_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_byte(input string name, input spi_pkg::spi_byte_t expected,
                             input spi_pkg::spi_byte_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch %s expected %b actual %b", name, expected, actual);
      end
   endtask

   //########################################
   // Register port
   //########################################
   task automatic write_reg(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_data_t data);
      @(posedge sys_clk);
      reg_write <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge sys_clk);
      reg_write <= 1'b0;                       // Single cycle strobe
   endtask

   // Valid must be low in the strobe cycle and high in the next one
   task automatic read_reg(input string name, input spi_pkg::reg_addr_t addr,
                           output spi_pkg::reg_data_t data);
      @(posedge sys_clk);
      reg_read <= 1'b1;
      reg_addr <= addr;
      @(negedge sys_clk);
      check_bit({name, "_rvalid_early"}, 1'b0, reg_rvalid);
      @(posedge sys_clk);
      reg_read <= 1'b0;
      @(negedge sys_clk);
      check_bit({name, "_rvalid"}, 1'b1, reg_rvalid);
      data = reg_rdata;
   endtask

   task automatic wait_done(input string name);
      spi_pkg::reg_data_t status;
      logic               finished;
      finished = 1'b0;
      for (int polls = 0; polls < POLL_LIMIT && !finished; polls++) begin
         read_reg({name, "_poll"}, spi_pkg::ADDR_STATUS, status);
         finished = !status[0] && status[1];   // Idle with done flag up
      end
      if (!finished) begin
         timeouts++;
         $display("Transfer %s did not finish within %0d status polls", name, POLL_LIMIT);
      end
   endtask

   task automatic wait_busy(input string name);
      spi_pkg::reg_data_t status;
      logic               started;
      started = 1'b0;
      for (int polls = 0; polls < POLL_LIMIT && !started; polls++) begin
         read_reg({name, "_poll"}, spi_pkg::ADDR_STATUS, status);
         started = status[0];
      end
      if (!started) begin
         timeouts++;
         $display("Transfer %s never showed busy within %0d status polls", name, POLL_LIMIT);
      end
   endtask

   // One fixed row of the transfer table
   task automatic fill_row(input int idx, input string name, input spi_pkg::clk_div_t div,
                           input spi_pkg::spi_byte_t mbyte, input spi_pkg::spi_byte_t sbyte);
      row_name[idx]  = name;
      row_div[idx]   = div;
      row_mbyte[idx] = mbyte;
      row_sbyte[idx] = sbyte;
   endtask

   // One byte each way, then both flags cleared by their reads
   task automatic run_transfer(input string name, input spi_pkg::clk_div_t div,
                               input spi_pkg::spi_byte_t mbyte,
                               input spi_pkg::spi_byte_t sbyte, input logic irq_exp);
      spi_pkg::reg_data_t data;
      write_reg(spi_pkg::ADDR_SLAVE_TX, {24'd0, sbyte});
      write_reg(spi_pkg::ADDR_CONFIG, {24'd0, div});
      write_reg(spi_pkg::ADDR_TX, {24'd0, mbyte});
      wait_done(name);
      read_reg(name, spi_pkg::ADDR_STATUS, data);
      check_data({name, "_status"}, 32'h0000_0006, data);   // Slave and done set while idle
      check_bit({name, "_irq"}, irq_exp, irq);
      read_reg(name, spi_pkg::ADDR_RX, data);
      check_byte({name, "_rx"}, sbyte, data[7:0]);
      check_bit({name, "_irq_slave_only"}, irq_exp, irq);  // Slave flag still up
      read_reg(name, spi_pkg::ADDR_STATUS, data);
      check_data({name, "_status_rx_read"}, 32'h0000_0004, data);
      read_reg(name, spi_pkg::ADDR_SLAVE_RX, data);
      check_byte({name, "_slave_rx"}, mbyte, data[7:0]);
      check_bit({name, "_irq_cleared"}, 1'b0, irq);
      read_reg(name, spi_pkg::ADDR_STATUS, data);
      check_data({name, "_status_clear"}, 32'h0000_0000, data);
   endtask

   //########################################
   // Main sequence
   //########################################
   initial begin
      seed_val  = 32'h931b952b;
      void'($urandom(seed_val));               // Seed once
      checks    = 0;
      errors    = 0;
      timeouts  = 0;
      reset     = 1'b1;
      reg_write = 1'b0;
      reg_read  = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;

      fill_row(0, "basic",    8'd8,  8'ha5, 8'h3c);
      fill_row(1, "div_zero", 8'd0,  8'hf0, 8'h0f);
      fill_row(2, "div_one",  8'd1,  8'h81, 8'h7e);
      fill_row(3, "div_min",  8'd4,  8'h00, 8'hff);
      fill_row(4, "div_odd",  8'd13, 8'hc3, 8'h5a);
      for (int i = NFIXED; i < NROWS; i++) begin
         row_name[i]  = $sformatf("random_%0d", i - NFIXED);
         row_div[i]   = 8'($urandom % 16);     // Covers the clamped range too
         row_mbyte[i] = 8'($urandom);
         row_sbyte[i] = 8'($urandom);
      end

      repeat (2) @(posedge sys_clk);
      reset <= 1'b0;
      @(negedge sys_clk);

      // Reset state
      check_bit("reset_irq", 1'b0, irq);
      check_bit("reset_rvalid", 1'b0, reg_rvalid);
      check_bit("reset_ss_pin", 1'b1, gpio[spi_pkg::PIN_M_SS]);
      check_bit("reset_sclk_pin", 1'b0, gpio[spi_pkg::PIN_M_SCLK]);
      read_reg("reset_config", spi_pkg::ADDR_CONFIG, rdata);
      check_data("reset_config", {24'd0, spi_pkg::CONFIG_RESET}, rdata);
      read_reg("reset_status", spi_pkg::ADDR_STATUS, rdata);
      check_data("reset_status", 32'd0, rdata);
      read_reg("reset_irq_en", spi_pkg::ADDR_IRQ_EN, rdata);
      check_data("reset_irq_en", 32'd0, rdata);

      // Readback masked to field widths
      write_reg(spi_pkg::ADDR_CONFIG, 32'hdead_be37);
      read_reg("rb_config", spi_pkg::ADDR_CONFIG, rdata);
      check_data("rb_config", 32'h0000_0037, rdata);
      write_reg(spi_pkg::ADDR_IRQ_EN, 32'hffff_fffd);
      read_reg("rb_irq_en", spi_pkg::ADDR_IRQ_EN, rdata);
      check_data("rb_irq_en", 32'h0000_0001, rdata);
      write_reg(spi_pkg::ADDR_SLAVE_TX, 32'h1234_56c9);
      read_reg("rb_slave_tx", spi_pkg::ADDR_SLAVE_TX, rdata);
      check_data("rb_slave_tx", 32'h0000_00c9, rdata);
      read_reg("rb_unmapped", 4'hf, rdata);
      check_data("rb_unmapped", 32'd0, rdata);
      write_reg(spi_pkg::ADDR_IRQ_EN, 32'd0);

      // Table rows with interrupts masked
      for (int i = 0; i < NROWS; i++)
         run_transfer(row_name[i], row_div[i], row_mbyte[i], row_sbyte[i], 1'b0);

      // Both enables on
      write_reg(spi_pkg::ADDR_IRQ_EN, 32'h0000_0003);
      run_transfer("irq_both", 8'd6, 8'h5a, 8'ha5, 1'b1);
      write_reg(spi_pkg::ADDR_IRQ_EN, 32'd0);

      // Second TX write lands mid transfer
      write_reg(spi_pkg::ADDR_SLAVE_TX, 32'h0000_0096);
      write_reg(spi_pkg::ADDR_CONFIG, 32'h0000_0008);
      write_reg(spi_pkg::ADDR_TX, 32'h0000_0069);
      wait_busy("busy_drop");
      write_reg(spi_pkg::ADDR_TX, 32'h0000_0011);   // Dropped
      wait_done("busy_drop");
      read_reg("busy_drop", spi_pkg::ADDR_RX, rdata);
      check_byte("busy_drop_rx", 8'h96, rdata[7:0]);
      read_reg("busy_drop", spi_pkg::ADDR_SLAVE_RX, rdata);
      check_byte("busy_drop_slave_rx", 8'h69, rdata[7:0]);
      read_reg("busy_drop", spi_pkg::ADDR_STATUS, rdata);
      check_data("busy_drop_status", 32'd0, rdata); // No second transfer

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/spi_top.sv */
/*
 * SPI subsystem top level
 * Register block, mode 0 master and slave, and the shared
 * general-purpose pin bank
 */
`timescale 1ns/1ns
`default_nettype none

module spi_top (
   input  wire logic               sys_clk,
   input  wire logic               reset,
   input  wire logic               reg_write,
   input  wire logic               reg_read,
   input  wire spi_pkg::reg_addr_t reg_addr,
   input  wire spi_pkg::reg_data_t reg_wdata,
   output spi_pkg::reg_data_t      reg_rdata,
   output logic                    reg_rvalid,
   output logic                    irq,
   inout  wire spi_pkg::gpio_t     gpio
);

   //########################################
   // Internal wiring
   //########################################
   logic               tx_start;               // Regs to master
   spi_pkg::spi_byte_t tx_byte;
   spi_pkg::clk_div_t  clk_div;
   logic               busy;                   // Master to regs
   logic               done;
   spi_pkg::spi_byte_t rx_byte;
   spi_pkg::spi_byte_t slave_tx_byte;          // Regs to slave
   logic               slave_rx_strobe;        // Slave to regs
   spi_pkg::spi_byte_t slave_rx_byte;
   logic               m_sclk;                 // Master pins
   logic               m_mosi;
   logic               m_ss;
   logic               m_miso;
   logic               s_sclk;                 // Slave pins, synchronized
   logic               s_mosi;
   logic               s_ss;
   logic               s_miso;

   spi_regs spi_regs_i (
      .sys_clk, .reset,
      .reg_write, .reg_read, .reg_addr, .reg_wdata,
      .reg_rdata, .reg_rvalid, .irq,
      .busy, .done, .rx_byte,
      .slave_rx_strobe, .slave_rx_byte,
      .tx_start, .tx_byte, .clk_div, .slave_tx_byte
   );

   spi_master spi_master_i (
      .sys_clk, .reset,
      .tx_start, .tx_byte, .clk_div,
      .m_miso,
      .busy, .done, .rx_byte,
      .m_sclk, .m_mosi, .m_ss
   );

   spi_slave spi_slave_i (
      .sys_clk, .reset,
      .s_sclk, .s_mosi, .s_ss,
      .slave_tx_byte,
      .s_miso, .slave_rx_strobe, .slave_rx_byte
   );

   spi_pads spi_pads_i (
      .sys_clk, .reset,
      .m_sclk, .m_mosi, .m_ss, .s_miso,
      .m_miso, .s_sclk, .s_mosi, .s_ss,
      .gpio
   );

endmodule

`default_nettype wire

/* verilog/spi_pads.sv */
/*
 * SPI pin bank
 * Drives or releases each pin by the fixed direction table and
 * passes the SPI inputs through two-flop synchronizers
 */
`timescale 1ns/1ns
`default_nettype none

module spi_pads (
   input  wire logic           sys_clk,
   input  wire logic           reset,
   input  wire logic           m_sclk,
   input  wire logic           m_mosi,
   input  wire logic           m_ss,
   input  wire logic           s_miso,
   output logic                m_miso,
   output logic                s_sclk,
   output logic                s_mosi,
   output logic                s_ss,
   inout  wire spi_pkg::gpio_t gpio
);

   spi_pkg::gpio_t pin_out;                    // Output value per pin
   logic [3:0]     sync_a;                     // {ss, mosi, sclk, miso}
   logic [3:0]     sync_b;

   always_comb begin
      pin_out                      = '0;
      pin_out[spi_pkg::PIN_M_SCLK] = m_sclk;
      pin_out[spi_pkg::PIN_M_MOSI] = m_mosi;
      pin_out[spi_pkg::PIN_M_SS]   = m_ss;
      pin_out[spi_pkg::PIN_S_MISO] = s_miso;
   end

   // Input pins float here
   for (genvar i = 0; i < spi_pkg::NGPIO; i++) begin : g_pin
      assign gpio[i] = spi_pkg::GPIO_DIR[i] ? pin_out[i] : 1'bz;
   end

   //########################################
   // Input synchronizers
   //########################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         sync_a <= 4'b1000;                    // SS idles high
         sync_b <= 4'b1000;
      end else begin
         sync_a <= {gpio[spi_pkg::PIN_S_SS], gpio[spi_pkg::PIN_S_MOSI],
                    gpio[spi_pkg::PIN_S_SCLK], gpio[spi_pkg::PIN_M_MISO]};
         sync_b <= sync_a;
      end
   end

   assign {s_ss, s_mosi, s_sclk, m_miso} = sync_b;

endmodule

`default_nettype wire

/* verilog/spi_slave.sv */
/*
 * SPI slave, mode 0
 * Oversamples synchronized SCLK, MOSI and SS in the system clock
 * domain, returns a preloaded byte and captures the received one
 */
`timescale 1ns/1ns
`default_nettype none

module spi_slave (
   input  wire logic               sys_clk,
   input  wire logic               reset,
   input  wire logic               s_sclk,
   input  wire logic               s_mosi,
   input  wire logic               s_ss,
   input  wire spi_pkg::spi_byte_t slave_tx_byte,
   output logic                    s_miso,
   output logic                    slave_rx_strobe,
   output spi_pkg::spi_byte_t      slave_rx_byte
);

   logic               sclk_q;                 // Previous SCLK sample
   logic               ss_q;                   // Previous SS sample
   logic               sclk_rise;
   logic               sclk_fall;
   logic               ss_fall;
   logic [2:0]         bit_cnt;
   spi_pkg::spi_byte_t tx_shift;
   spi_pkg::spi_byte_t rx_shift;

   assign sclk_rise = s_sclk & ~sclk_q;
   assign sclk_fall = ~s_sclk & sclk_q;
   assign ss_fall   = ss_q & ~s_ss;
   assign s_miso    = tx_shift[7];

   //########################################
   // Edge detect and bit count
   //########################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         sclk_q          <= 1'b0;
         ss_q            <= 1'b1;              // Deselected
         bit_cnt         <= '0;
         tx_shift        <= '0;                // MISO low out of reset
         slave_rx_strobe <= 1'b0;
      end else begin
         sclk_q          <= s_sclk;
         ss_q            <= s_ss;
         slave_rx_strobe <= 1'b0;
         if (ss_fall) begin
            tx_shift <= slave_tx_byte;         // Preload reply
            bit_cnt  <= '0;
         end else if (s_ss) begin
            bit_cnt  <= '0;                    // Partial byte dropped
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
               slave_rx_strobe <= 1'b1;
         end else if (sclk_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
      end
   end

   //########################################
   // Receive path
   //########################################
   always_ff @(posedge sys_clk) begin
      if (sclk_rise && !s_ss) begin
         rx_shift <= {rx_shift[6:0], s_mosi};  // Sample on rising edge
         if (bit_cnt == 3'd7)
            slave_rx_byte <= {rx_shift[6:0], s_mosi};
      end
   end

   // A finished byte only ever comes out of a selected frame
   a_strobe_selected: assert property (
      @(posedge sys_clk) disable iff (reset) slave_rx_strobe |-> !s_ss);

endmodule

`default_nettype wire

/* verilog/spi_master.sv */
/*
 * SPI master, mode 0, one byte per transfer
 * SS setup half period, eight SCLK periods MSB first, SS hold
 * half period, then a done pulse with the received byte
 */
`timescale 1ns/1ns
`default_nettype none

module spi_master (
   input  wire logic               sys_clk,
   input  wire logic               reset,
   input  wire logic               tx_start,
   input  wire spi_pkg::spi_byte_t tx_byte,
   input  wire spi_pkg::clk_div_t  clk_div,
   input  wire logic               m_miso,
   output logic                    busy,
   output logic                    done,
   output spi_pkg::spi_byte_t      rx_byte,
   output logic                    m_sclk,
   output logic                    m_mosi,
   output logic                    m_ss
);

   spi_pkg::master_state_t state;
   spi_pkg::clk_div_t      half_len;           // Clamped half period
   spi_pkg::clk_div_t      half_cnt;           // Counts down to phase end
   spi_pkg::spi_byte_t     tx_shift;
   spi_pkg::spi_byte_t     rx_shift;
   logic [2:0]             bit_cnt;
   spi_pkg::clk_div_t      div_clamped;
   logic                   phase_end;
   logic                   sclk_fall;

   assign div_clamped = (clk_div < spi_pkg::SPI_MIN_HALF) ? spi_pkg::SPI_MIN_HALF : clk_div;
   assign phase_end   = (half_cnt == '0);
   assign sclk_fall   = (state == spi_pkg::SHIFT) && phase_end && m_sclk;

   assign busy    = (state != spi_pkg::IDLE);
   assign m_mosi  = tx_shift[7];               // MSB first
   assign rx_byte = rx_shift;

   //########################################
   // Control FSM
   //########################################
   always_ff @(posedge sys_clk) begin
      done <= 1'b0;
      if (reset) begin
         state    <= spi_pkg::IDLE;
         m_sclk   <= 1'b0;                     // Mode 0 idles low
         m_ss     <= 1'b1;
         bit_cnt  <= '0;
         half_cnt <= '0;
      end else begin
         if (state == spi_pkg::IDLE)
            half_cnt <= div_clamped - 8'd1;
         else if (phase_end)
            half_cnt <= half_len - 8'd1;       // Reload per half period
         else
            half_cnt <= half_cnt - 8'd1;

         case (state)
            spi_pkg::IDLE: begin
               bit_cnt <= '0;
               if (tx_start)
                  state <= spi_pkg::SELECT;
            end
            spi_pkg::SELECT: begin
               m_ss <= 1'b0;                   // Setup half period
               if (phase_end)
                  state <= spi_pkg::SHIFT;
            end
            spi_pkg::SHIFT: begin
               if (phase_end) begin
                  m_sclk <= !m_sclk;
                  if (m_sclk) begin            // Falling edge ends a bit
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7)
                        state <= spi_pkg::DESELECT;
                  end
               end
            end
            spi_pkg::DESELECT: begin
               if (phase_end) begin            // Hold done
                  m_ss  <= 1'b1;
                  done  <= 1'b1;
                  state <= spi_pkg::IDLE;
               end
            end
            default: state <= spi_pkg::IDLE;
         endcase
      end
   end

   //########################################
   // Data path
   //########################################
   always_ff @(posedge sys_clk) begin
      if ((state == spi_pkg::IDLE) && tx_start) begin
         half_len <= div_clamped;
         tx_shift <= tx_byte;
      end else if (sclk_fall) begin
         tx_shift <= {tx_shift[6:0], 1'b0};    // Next MOSI bit after falling edge
      end
      // MISO crosses the pad synchronizers, so the bit is taken at the
      // close of the high phase where it has long been stable
      if (sclk_fall)
         rx_shift <= {rx_shift[6:0], m_miso};
   end

   // SS stays low for the whole shift phase
   a_ss_low_in_shift: assert property (
      @(posedge sys_clk) disable iff (reset) (state == spi_pkg::SHIFT) |-> !m_ss);

endmodule

`default_nettype wire

/* verilog/spi_regs.sv */
/*
 * SPI register block
 * Host strobe port, configuration and byte registers, sticky
 * done and slave flags, registered read mux and interrupt
 */
`timescale 1ns/1ns
`default_nettype none

module spi_regs (
   input  wire logic               sys_clk,
   input  wire logic               reset,
   input  wire logic               reg_write,
   input  wire logic               reg_read,
   input  wire spi_pkg::reg_addr_t reg_addr,
   input  wire spi_pkg::reg_data_t reg_wdata,
   output spi_pkg::reg_data_t      reg_rdata,
   output logic                    reg_rvalid,
   output logic                    irq,
   input  wire logic               busy,
   input  wire logic               done,
   input  wire spi_pkg::spi_byte_t rx_byte,
   input  wire logic               slave_rx_strobe,
   input  wire spi_pkg::spi_byte_t slave_rx_byte,
   output logic                    tx_start,
   output spi_pkg::spi_byte_t      tx_byte,
   output spi_pkg::clk_div_t       clk_div,
   output spi_pkg::spi_byte_t      slave_tx_byte
);

   logic [1:0]         irq_en;                 // Bit 0 done, bit 1 slave
   logic               done_flag;
   logic               slave_flag;
   spi_pkg::spi_byte_t master_rx;              // Captured master byte
   spi_pkg::spi_byte_t slave_rx;               // Captured slave byte
   logic               tx_accept;
   logic               rd_rx;
   logic               rd_slave_rx;

   // Drop TX while busy or while a start is still on its way
   assign tx_accept   = reg_write && (reg_addr == spi_pkg::ADDR_TX) && !busy && !tx_start;
   assign rd_rx       = reg_read && (reg_addr == spi_pkg::ADDR_RX);
   assign rd_slave_rx = reg_read && (reg_addr == spi_pkg::ADDR_SLAVE_RX);

   //########################################
   // Writes
   //########################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         clk_div       <= spi_pkg::CONFIG_RESET;
         irq_en        <= '0;
         slave_tx_byte <= '0;
         tx_start      <= 1'b0;
      end else begin
         tx_start <= tx_accept;                // One cycle pulse
         if (reg_write) begin
            case (reg_addr)
               spi_pkg::ADDR_CONFIG:   clk_div       <= reg_wdata[7:0];
               spi_pkg::ADDR_SLAVE_TX: slave_tx_byte <= reg_wdata[7:0];
               spi_pkg::ADDR_IRQ_EN:   irq_en        <= reg_wdata[1:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (tx_accept)
         tx_byte <= reg_wdata[7:0];
      if (done)
         master_rx <= rx_byte;
      if (slave_rx_strobe)
         slave_rx <= slave_rx_byte;
   end

   //########################################
   // Sticky flags
   //########################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         done_flag  <= 1'b0;
         slave_flag <= 1'b0;
      end else begin
         if (done)                             // Set wins over a clearing read
            done_flag <= 1'b1;
         else if (rd_rx)
            done_flag <= 1'b0;
         if (slave_rx_strobe)
            slave_flag <= 1'b1;
         else if (rd_slave_rx)
            slave_flag <= 1'b0;
      end
   end

   assign irq = (done_flag & irq_en[0]) | (slave_flag & irq_en[1]);

   //########################################
   // Read mux
   //########################################
   always_ff @(posedge sys_clk) begin
      if (reset)
         reg_rvalid <= 1'b0;
      else
         reg_rvalid <= reg_read;               // Fixed one cycle latency
   end

   always_ff @(posedge sys_clk) begin
      if (reg_read) begin
         case (reg_addr)
            spi_pkg::ADDR_CONFIG:   reg_rdata <= {24'd0, clk_div};
            spi_pkg::ADDR_STATUS:   reg_rdata <= {29'd0, slave_flag, done_flag, busy};
            spi_pkg::ADDR_RX:       reg_rdata <= {24'd0, master_rx};
            spi_pkg::ADDR_SLAVE_TX: reg_rdata <= {24'd0, slave_tx_byte};
            spi_pkg::ADDR_SLAVE_RX: reg_rdata <= {24'd0, slave_rx};
            spi_pkg::ADDR_IRQ_EN:   reg_rdata <= {30'd0, irq_en};
            default:                reg_rdata <= '0;  // Unmapped reads zero
         endcase
      end
   end

   // Every valid answers the strobe of the cycle before
   a_rvalid_follows_read: assert property (
      @(posedge sys_clk) disable iff (reset) reg_rvalid |-> $past(reg_read));

endmodule

`default_nettype wire

/* verilog/spi_pkg.sv */
/*
 * SPI subsystem package
 * Register map, pin assignment, divider limits and shared types
 * for the register block, SPI master, SPI slave and pad logic
 */
`default_nettype none

package spi_pkg;

   //########################################
   // Widths
   //########################################
   localparam int NGPIO = 24;                  // Pins in the bank

   typedef logic [3:0]       reg_addr_t;       // Register word address
   typedef logic [31:0]      reg_data_t;       // Register data
   typedef logic [7:0]       spi_byte_t;       // One SPI byte
   typedef logic [7:0]       clk_div_t;        // SCLK half period in clocks
   typedef logic [NGPIO-1:0] gpio_t;           // Pin bank

   typedef enum logic [1:0] {IDLE, SELECT, SHIFT, DESELECT} master_state_t;

   //########################################
   // Register map
   //########################################
   localparam reg_addr_t ADDR_CONFIG   = 4'd0; // Divider in 7:0
   localparam reg_addr_t ADDR_STATUS   = 4'd1; // Busy, done, slave received
   localparam reg_addr_t ADDR_TX       = 4'd2; // Write starts a transfer
   localparam reg_addr_t ADDR_RX       = 4'd3; // Read clears done
   localparam reg_addr_t ADDR_SLAVE_TX = 4'd4;
   localparam reg_addr_t ADDR_SLAVE_RX = 4'd5; // Read clears slave flag
   localparam reg_addr_t ADDR_IRQ_EN   = 4'd6; // Done and slave enables

   localparam clk_div_t CONFIG_RESET = 8'd8;   // Divider after reset
   localparam clk_div_t SPI_MIN_HALF = 8'd4;   // Floor so the slave sees each edge

   //########################################
   // Pin map
   //########################################
   localparam int PIN_M_SCLK = 3;
   localparam int PIN_M_MOSI = 4;
   localparam int PIN_M_MISO = 5;
   localparam int PIN_M_SS   = 6;
   localparam int PIN_S_SCLK = 7;
   localparam int PIN_S_MOSI = 8;
   localparam int PIN_S_MISO = 9;
   localparam int PIN_S_SS   = 10;

   // Driven pins carry a 1 in the direction table
   localparam gpio_t GPIO_DIR = gpio_t'((1 << PIN_M_SCLK) | (1 << PIN_M_MOSI) |
                                        (1 << PIN_M_SS)   | (1 << PIN_S_MISO));

endpackage

`default_nettype wire
